// File: verilog/dispatch_pkg.sv
`default_nettype none

package dispatch_pkg;

    // rob slot index, 32 slots handed out in even/odd pairs
    localparam int ROB_ID_W = 5;
    // physical register number, 64 registers
    localparam int PRF_W = 6;
    // architectural register number
    localparam int LREG_W = 5;

    // derived sizes
    localparam int ROB_PAIR_W = ROB_ID_W - 1;
    localparam int ROB_CNT_W = ROB_ID_W + 1;
    localparam int PRF_NUM = 1 << PRF_W;

    // head pointer is {wrap, pair index}
    typedef logic [ROB_ID_W-1:0] rob_head_t;
    // full id is {wrap, pair index, odd slot}
    typedef logic [ROB_ID_W:0] rob_id_t;
    // free slot count, 0 up to 32
    typedef logic [ROB_CNT_W-1:0] rob_cnt_t;
    typedef logic [PRF_W-1:0] prf_num_t;
    typedef logic [LREG_W-1:0] lreg_t;

    localparam rob_cnt_t ROB_SLOTS = rob_cnt_t'(1 << ROB_ID_W);

    // micro-op opcodes after decode
    typedef enum logic [4:0] {
        NOP_U,
        MDBUBBLE_U,
        ADD_U,
        SUB_U,
        AND_U,
        OR_U,
        SLT_U,
        MULTHI_U,
        MULTLO_U,
        MULTUHI_U,
        MULTULO_U,
        DIV_U,
        LW_U,
        SB_U,
        SH_U,
        SW_U,
        SWL_U,
        SWR_U
    } uop_e;

    // target reservation station
    typedef enum logic [1:0] {
        RS_NONE,
        RS_ALU,
        RS_MDU,
        RS_LSU
    } rs_type_e;

    // one renamed micro-op
    typedef struct packed {
        logic     valid;
        uop_e     uop;
        rs_type_e rs_type;
        logic     op0re;
        lreg_t    op0_laddr;
        prf_num_t op0_paddr;
        logic     op1re;
        lreg_t    op1_laddr;
        prf_num_t op1_paddr;
        logic     dstwe;
        prf_num_t dst_paddr;
        rob_id_t  id;
        logic     busy;
    } uop_bundle_t;

    // source operand readiness at dispatch
    typedef struct packed {
        logic prs1_rdy;
        logic prs2_rdy;
    } arbitration_info_t;

    typedef struct packed {
        uop_bundle_t       ops;
        arbitration_info_t rdys;
    } alu_queue_meta_t;

    typedef struct packed {
        uop_bundle_t       ops;
        arbitration_info_t rdys;
        logic              is_store;
    } lsu_queue_meta_t;

    // mdu takes the whole pair, hi half from inst 0
    typedef struct packed {
        uop_bundle_t       ops_hi;
        uop_bundle_t       ops_lo;
        arbitration_info_t rdys;
        logic              is_mul;
    } mdu_queue_meta_t;

endpackage

`default_nettype wire

// File: verilog/rob_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module rob_alloc (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    alloc,
    input  logic                    commit_pair,
    output dispatch_pkg::rob_head_t rob_head,
    output logic                    rob_ready
);

    // pair pointer and the wrap bit above it
    logic [dispatch_pkg::ROB_PAIR_W-1:0] head_pair;
    logic                                head_wrap;
    dispatch_pkg::rob_cnt_t              free_cnt;
    logic                                do_alloc;
    logic                                do_commit;

    assign rob_head = {head_wrap, head_pair};

    // one whole pair must be free
    assign rob_ready = free_cnt >= dispatch_pkg::rob_cnt_t'(2);

    // alloc only lands when a pair is free
    assign do_alloc = alloc && rob_ready;
    // commit with nothing allocated is dropped
    assign do_commit = commit_pair && (free_cnt != dispatch_pkg::ROB_SLOTS);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_pair <= '0;
            head_wrap <= 1'b0;
            free_cnt  <= dispatch_pkg::ROB_SLOTS;
        end else begin
            // carry out of the pair index flips the wrap bit
            if (do_alloc) begin
                {head_wrap, head_pair} <= rob_head + dispatch_pkg::rob_head_t'(1);
            end
            // both at once leaves the count alone
            case ({do_alloc, do_commit})
                2'b10: begin
                    free_cnt <= free_cnt - dispatch_pkg::rob_cnt_t'(2);
                end
                2'b01: begin
                    free_cnt <= free_cnt + dispatch_pkg::rob_cnt_t'(2);
                end
                default: begin
                    free_cnt <= free_cnt;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/busy_table.sv
`timescale 1ns/1ps
`default_nettype none

module busy_table (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   set_0_en,
    input  dispatch_pkg::prf_num_t set_0_num,
    input  logic                   set_1_en,
    input  dispatch_pkg::prf_num_t set_1_num,
    input  logic                   wb_valid,
    input  dispatch_pkg::prf_num_t wb_num,
    input  dispatch_pkg::prf_num_t lookup_num_0,
    input  dispatch_pkg::prf_num_t lookup_num_1,
    input  dispatch_pkg::prf_num_t lookup_num_2,
    input  dispatch_pkg::prf_num_t lookup_num_3,
    output logic [3:0]             busy
);

    // one bit per physical register
    logic [dispatch_pkg::PRF_NUM-1:0] busy_q;
    logic [dispatch_pkg::PRF_NUM-1:0] busy_d;

    always_comb begin
        busy_d = busy_q;
        // writeback clears first
        if (wb_valid) begin
            busy_d[wb_num] = 1'b0;
        end
        // dispatch sets after, so a set wins on a clash
        if (set_0_en) begin
            busy_d[set_0_num] = 1'b1;
        end
        if (set_1_en) begin
            busy_d[set_1_num] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= '0;
        end else begin
            busy_q <= busy_d;
        end
    end

    // lookups see registered bits only
    // same-cycle writeback bypass lives in dispatch
    assign busy[0] = busy_q[lookup_num_0];
    assign busy[1] = busy_q[lookup_num_1];
    assign busy[2] = busy_q[lookup_num_2];
    assign busy[3] = busy_q[lookup_num_3];

endmodule

`default_nettype wire

// File: verilog/dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch (
    input  dispatch_pkg::uop_bundle_t     inst_0_ops,
    input  dispatch_pkg::uop_bundle_t     inst_1_ops,
    input  dispatch_pkg::rob_head_t       rob_head,
    input  logic                          rob_ready,
    input  logic [3:0]                    busy,
    input  logic                          wb_valid,
    input  dispatch_pkg::prf_num_t        wb_num,
    output logic                          alloc,
    output logic                          set_0_en,
    output dispatch_pkg::prf_num_t        set_0_num,
    output logic                          set_1_en,
    output dispatch_pkg::prf_num_t        set_1_num,
    output dispatch_pkg::prf_num_t        lookup_num_0,
    output dispatch_pkg::prf_num_t        lookup_num_1,
    output dispatch_pkg::prf_num_t        lookup_num_2,
    output dispatch_pkg::prf_num_t        lookup_num_3,
    output logic                          rs_alu_wen_0,
    output logic                          rs_alu_wen_1,
    output logic                          rs_lsu_wen_0,
    output logic                          rs_lsu_wen_1,
    output logic                          rs_mdu_wen_0,
    output dispatch_pkg::alu_queue_meta_t rs_alu_dout_0,
    output dispatch_pkg::alu_queue_meta_t rs_alu_dout_1,
    output dispatch_pkg::lsu_queue_meta_t rs_lsu_dout_0,
    output dispatch_pkg::lsu_queue_meta_t rs_lsu_dout_1,
    output dispatch_pkg::mdu_queue_meta_t rs_mdu_dout_0,
    output logic                          pause_req
);

    // stamp rob id, busy only for real work
    function automatic dispatch_pkg::uop_bundle_t tag_uop(
        input dispatch_pkg::uop_bundle_t u,
        input dispatch_pkg::rob_id_t     id
    );
        dispatch_pkg::uop_bundle_t t;
        t = u;
        t.id = id;
        t.busy = u.valid && (u.uop != dispatch_pkg::NOP_U) &&
                 (u.uop != dispatch_pkg::MDBUBBLE_U);
        return t;
    endfunction

    // r0 or no read is always ready
    // else blocked by busy without bypass, or by an older in-pair write
    function automatic logic src_ready(
        input logic                re,
        input dispatch_pkg::lreg_t laddr,
        input logic                busy_bit,
        input logic                wb_hit,
        input logic                pair_dep
    );
        logic needs;
        needs = re && (laddr != '0);
        return !needs || (!(busy_bit && !wb_hit) && !pair_dep);
    endfunction

    function automatic logic is_store_op(input dispatch_pkg::uop_e op);
        return (op == dispatch_pkg::SB_U) || (op == dispatch_pkg::SH_U) ||
               (op == dispatch_pkg::SW_U) || (op == dispatch_pkg::SWL_U) ||
               (op == dispatch_pkg::SWR_U);
    endfunction

    dispatch_pkg::uop_bundle_t       inst_0_tag;
    dispatch_pkg::uop_bundle_t       inst_1_tag;
    dispatch_pkg::arbitration_info_t inst_0_rdy;
    dispatch_pkg::arbitration_info_t inst_1_rdy;
    logic fire;
    logic inst_0_is_alu, inst_1_is_alu;
    logic inst_0_is_lsu, inst_1_is_lsu;
    logic inst_0_is_mdu;
    logic inst_0_is_mul;
    logic inst_0_wr_dst;

    // even slot to inst 0, odd slot to inst 1
    assign inst_0_tag = tag_uop(inst_0_ops, {rob_head, 1'b0});
    assign inst_1_tag = tag_uop(inst_1_ops, {rob_head, 1'b1});

    // whole pair waits when the rob is short
    assign fire = (inst_0_ops.valid || inst_1_ops.valid) && rob_ready;
    assign alloc = fire;
    assign pause_req = !rob_ready;

    // destination busy set
    assign set_0_en = fire && inst_0_ops.valid && inst_0_ops.dstwe;
    assign set_0_num = inst_0_ops.dst_paddr;
    assign set_1_en = fire && inst_1_ops.valid && inst_1_ops.dstwe;
    assign set_1_num = inst_1_ops.dst_paddr;

    // scoreboard lookups, busy[k] comes back in the same order
    assign lookup_num_0 = inst_0_ops.op0_paddr;
    assign lookup_num_1 = inst_0_ops.op1_paddr;
    assign lookup_num_2 = inst_1_ops.op0_paddr;
    assign lookup_num_3 = inst_1_ops.op1_paddr;

    // inst 0 result not yet in the table
    assign inst_0_wr_dst = inst_0_ops.valid && inst_0_ops.dstwe;

    assign inst_0_rdy.prs1_rdy = src_ready(inst_0_ops.op0re, inst_0_ops.op0_laddr, busy[0],
                                           wb_valid && (wb_num == lookup_num_0), 1'b0);
    assign inst_0_rdy.prs2_rdy = src_ready(inst_0_ops.op1re, inst_0_ops.op1_laddr, busy[1],
                                           wb_valid && (wb_num == lookup_num_1), 1'b0);
    assign inst_1_rdy.prs1_rdy = src_ready(inst_1_ops.op0re, inst_1_ops.op0_laddr, busy[2],
                                           wb_valid && (wb_num == lookup_num_2),
                                           inst_0_wr_dst && (set_0_num == lookup_num_2));
    assign inst_1_rdy.prs2_rdy = src_ready(inst_1_ops.op1re, inst_1_ops.op1_laddr, busy[3],
                                           wb_valid && (wb_num == lookup_num_3),
                                           inst_0_wr_dst && (set_0_num == lookup_num_3));

    // station decode, invalid slots steer nowhere
    assign inst_0_is_alu = inst_0_ops.valid && (inst_0_ops.rs_type == dispatch_pkg::RS_ALU);
    assign inst_1_is_alu = inst_1_ops.valid && (inst_1_ops.rs_type == dispatch_pkg::RS_ALU);
    assign inst_0_is_lsu = inst_0_ops.valid && (inst_0_ops.rs_type == dispatch_pkg::RS_LSU);
    assign inst_1_is_lsu = inst_1_ops.valid && (inst_1_ops.rs_type == dispatch_pkg::RS_LSU);
    assign inst_0_is_mdu = inst_0_ops.valid && (inst_0_ops.rs_type == dispatch_pkg::RS_MDU);

    assign inst_0_is_mul = (inst_0_ops.uop == dispatch_pkg::MULTHI_U) ||
                           (inst_0_ops.uop == dispatch_pkg::MULTLO_U) ||
                           (inst_0_ops.uop == dispatch_pkg::MULTUHI_U) ||
                           (inst_0_ops.uop == dispatch_pkg::MULTULO_U);

    // port 0 takes either, port 1 only when both match
    assign rs_alu_wen_0 = fire && (inst_0_is_alu || inst_1_is_alu);
    assign rs_alu_wen_1 = fire && inst_0_is_alu && inst_1_is_alu;
    assign rs_lsu_wen_0 = fire && (inst_0_is_lsu || inst_1_is_lsu);
    assign rs_lsu_wen_1 = fire && inst_0_is_lsu && inst_1_is_lsu;
    // mdu issues as the head of a pair only
    assign rs_mdu_wen_0 = fire && inst_0_is_mdu;

    always_comb begin
        // alu compaction
        rs_alu_dout_0.ops  = inst_0_is_alu ? inst_0_tag : inst_1_tag;
        rs_alu_dout_0.rdys = inst_0_is_alu ? inst_0_rdy : inst_1_rdy;
        rs_alu_dout_1.ops  = inst_1_tag;
        rs_alu_dout_1.rdys = inst_1_rdy;

        // lsu compaction, store flag follows its uop
        rs_lsu_dout_0.ops      = inst_0_is_lsu ? inst_0_tag : inst_1_tag;
        rs_lsu_dout_0.rdys     = inst_0_is_lsu ? inst_0_rdy : inst_1_rdy;
        rs_lsu_dout_0.is_store = is_store_op(rs_lsu_dout_0.ops.uop);
        rs_lsu_dout_1.ops      = inst_1_tag;
        rs_lsu_dout_1.rdys     = inst_1_rdy;
        rs_lsu_dout_1.is_store = is_store_op(inst_1_ops.uop);

        // mdu carries both halves
        rs_mdu_dout_0.ops_hi = inst_0_tag;
        rs_mdu_dout_0.ops_lo = inst_1_tag;
        rs_mdu_dout_0.rdys   = inst_0_rdy;
        rs_mdu_dout_0.is_mul = inst_0_is_mul;
    end

endmodule

`default_nettype wire

// File: verilog/dispatch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_stage (
    input  logic                          clk,
    input  logic                          arst_n,
    input  dispatch_pkg::uop_bundle_t     inst_0_ops,
    input  dispatch_pkg::uop_bundle_t     inst_1_ops,
    input  logic                          wb_valid,
    input  dispatch_pkg::prf_num_t        wb_num,
    input  logic                          commit_pair,
    output logic                          rs_alu_wen_0,
    output logic                          rs_alu_wen_1,
    output logic                          rs_lsu_wen_0,
    output logic                          rs_lsu_wen_1,
    output logic                          rs_mdu_wen_0,
    output dispatch_pkg::alu_queue_meta_t rs_alu_dout_0,
    output dispatch_pkg::alu_queue_meta_t rs_alu_dout_1,
    output dispatch_pkg::lsu_queue_meta_t rs_lsu_dout_0,
    output dispatch_pkg::lsu_queue_meta_t rs_lsu_dout_1,
    output dispatch_pkg::mdu_queue_meta_t rs_mdu_dout_0,
    output logic                          pause_req
);

    // allocator to dispatch
    logic                    alloc;
    dispatch_pkg::rob_head_t rob_head;
    logic                    rob_ready;
    // dispatch to scoreboard
    logic                    set_0_en;
    dispatch_pkg::prf_num_t  set_0_num;
    logic                    set_1_en;
    dispatch_pkg::prf_num_t  set_1_num;
    dispatch_pkg::prf_num_t  lookup_num_0;
    dispatch_pkg::prf_num_t  lookup_num_1;
    dispatch_pkg::prf_num_t  lookup_num_2;
    dispatch_pkg::prf_num_t  lookup_num_3;
    logic [3:0]              busy;

    rob_alloc i_rob_alloc (
        .clk         (clk),
        .arst_n      (arst_n),
        .alloc       (alloc),
        .commit_pair (commit_pair),
        .rob_head    (rob_head),
        .rob_ready   (rob_ready)
    );

    busy_table i_busy_table (
        .clk          (clk),
        .arst_n       (arst_n),
        .set_0_en     (set_0_en),
        .set_0_num    (set_0_num),
        .set_1_en     (set_1_en),
        .set_1_num    (set_1_num),
        .wb_valid     (wb_valid),
        .wb_num       (wb_num),
        .lookup_num_0 (lookup_num_0),
        .lookup_num_1 (lookup_num_1),
        .lookup_num_2 (lookup_num_2),
        .lookup_num_3 (lookup_num_3),
        .busy         (busy)
    );

    // writeback also feeds dispatch for the bypass
    dispatch i_dispatch (
        .inst_0_ops    (inst_0_ops),
        .inst_1_ops    (inst_1_ops),
        .rob_head      (rob_head),
        .rob_ready     (rob_ready),
        .busy          (busy),
        .wb_valid      (wb_valid),
        .wb_num        (wb_num),
        .alloc         (alloc),
        .set_0_en      (set_0_en),
        .set_0_num     (set_0_num),
        .set_1_en      (set_1_en),
        .set_1_num     (set_1_num),
        .lookup_num_0  (lookup_num_0),
        .lookup_num_1  (lookup_num_1),
        .lookup_num_2  (lookup_num_2),
        .lookup_num_3  (lookup_num_3),
        .rs_alu_wen_0  (rs_alu_wen_0),
        .rs_alu_wen_1  (rs_alu_wen_1),
        .rs_lsu_wen_0  (rs_lsu_wen_0),
        .rs_lsu_wen_1  (rs_lsu_wen_1),
        .rs_mdu_wen_0  (rs_mdu_wen_0),
        .rs_alu_dout_0 (rs_alu_dout_0),
        .rs_alu_dout_1 (rs_alu_dout_1),
        .rs_lsu_dout_0 (rs_lsu_dout_0),
        .rs_lsu_dout_1 (rs_lsu_dout_1),
        .rs_mdu_dout_0 (rs_mdu_dout_0),
        .pause_req     (pause_req)
    );

endmodule

`default_nettype wire

// File: bench/dispatch_stage_assert.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_stage_assert (
    input logic clk,
    input logic arst_n,
    input logic rs_alu_wen_0,
    input logic rs_alu_wen_1,
    input logic rs_lsu_wen_0,
    input logic rs_lsu_wen_1,
    input logic rs_mdu_wen_0,
    input logic pause_req
);

    // stalled stage writes no station
    pause_blocks_wen: assert property (@(posedge clk) disable iff (!arst_n)
        pause_req |-> !(rs_alu_wen_0 || rs_alu_wen_1 || rs_lsu_wen_0 ||
                        rs_lsu_wen_1 || rs_mdu_wen_0))
        else $error("station write enable high while pause_req is set");

    // port 1 only fills behind port 0
    alu_compact: assert property (@(posedge clk) disable iff (!arst_n)
        rs_alu_wen_1 |-> rs_alu_wen_0)
        else $error("alu port 1 written without port 0");

    lsu_compact: assert property (@(posedge clk) disable iff (!arst_n)
        rs_lsu_wen_1 |-> rs_lsu_wen_0)
        else $error("lsu port 1 written without port 0");

endmodule

bind dispatch_stage dispatch_stage_assert i_dispatch_stage_assert (
    .clk          (clk),
    .arst_n       (arst_n),
    .rs_alu_wen_0 (rs_alu_wen_0),
    .rs_alu_wen_1 (rs_alu_wen_1),
    .rs_lsu_wen_0 (rs_lsu_wen_0),
    .rs_lsu_wen_1 (rs_lsu_wen_1),
    .rs_mdu_wen_0 (rs_mdu_wen_0),
    .pause_req    (pause_req)
);

`default_nettype wire

// File: bench/dispatch_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_stage_tb;

    localparam int RAND_CYCLES = 3000;
    localparam int WAIT_LIMIT = 40;

    logic                          clk;
    logic                          arst_n;
    dispatch_pkg::uop_bundle_t     inst_0_ops;
    dispatch_pkg::uop_bundle_t     inst_1_ops;
    logic                          wb_valid;
    dispatch_pkg::prf_num_t        wb_num;
    logic                          commit_pair;
    logic                          rs_alu_wen_0;
    logic                          rs_alu_wen_1;
    logic                          rs_lsu_wen_0;
    logic                          rs_lsu_wen_1;
    logic                          rs_mdu_wen_0;
    dispatch_pkg::alu_queue_meta_t rs_alu_dout_0;
    dispatch_pkg::alu_queue_meta_t rs_alu_dout_1;
    dispatch_pkg::lsu_queue_meta_t rs_lsu_dout_0;
    dispatch_pkg::lsu_queue_meta_t rs_lsu_dout_1;
    dispatch_pkg::mdu_queue_meta_t rs_mdu_dout_0;
    logic                          pause_req;

    // model head as {wrap, pair} plus free count and busy bits
    logic [4:0]  head_m;
    int          free_m;
    logic [63:0] busy_m;

    dispatch_stage i_dispatch_stage (
        .clk           (clk),
        .arst_n        (arst_n),
        .inst_0_ops    (inst_0_ops),
        .inst_1_ops    (inst_1_ops),
        .wb_valid      (wb_valid),
        .wb_num        (wb_num),
        .commit_pair   (commit_pair),
        .rs_alu_wen_0  (rs_alu_wen_0),
        .rs_alu_wen_1  (rs_alu_wen_1),
        .rs_lsu_wen_0  (rs_lsu_wen_0),
        .rs_lsu_wen_1  (rs_lsu_wen_1),
        .rs_mdu_wen_0  (rs_mdu_wen_0),
        .rs_alu_dout_0 (rs_alu_dout_0),
        .rs_alu_dout_1 (rs_alu_dout_1),
        .rs_lsu_dout_0 (rs_lsu_dout_0),
        .rs_lsu_dout_1 (rs_lsu_dout_1),
        .rs_mdu_dout_0 (rs_mdu_dout_0),
        .pause_req     (pause_req)
    );

    always #20 clk = ~clk;

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            $display("Checks failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Checks failed");
        $fatal(1, "wait loop ran out");
    endtask

    // random micro-op biased toward alu and lsu
    // small register range so numbers collide
    function automatic dispatch_pkg::uop_bundle_t rand_uop();
        dispatch_pkg::uop_bundle_t u;
        int kind;
        kind = $urandom % 8;
        u.valid = ($urandom % 8) != 0;
        if (kind < 3) begin
            u.rs_type = dispatch_pkg::RS_ALU;
            u.uop = dispatch_pkg::uop_e'(5'(2 + $urandom % 5));
        end else if (kind < 6) begin
            u.rs_type = dispatch_pkg::RS_LSU;
            u.uop = dispatch_pkg::uop_e'(5'(12 + $urandom % 6));
        end else if (kind == 6) begin
            u.rs_type = dispatch_pkg::RS_MDU;
            u.uop = dispatch_pkg::uop_e'(5'(7 + $urandom % 5));
        end else begin
            u.rs_type = dispatch_pkg::RS_NONE;
            u.uop = dispatch_pkg::uop_e'(5'($urandom % 2));
        end
        u.op0re = ($urandom % 4) != 0;
        u.op0_laddr = (($urandom % 8) == 0) ? '0 : dispatch_pkg::lreg_t'($urandom);
        u.op0_paddr = dispatch_pkg::prf_num_t'($urandom % 16);
        u.op1re = ($urandom % 4) != 0;
        u.op1_laddr = (($urandom % 8) == 0) ? '0 : dispatch_pkg::lreg_t'($urandom);
        u.op1_paddr = dispatch_pkg::prf_num_t'($urandom % 16);
        u.dstwe = ($urandom % 4) != 0;
        u.dst_paddr = dispatch_pkg::prf_num_t'($urandom % 16);
        // the DUT overwrites id and busy
        u.id = dispatch_pkg::rob_id_t'($urandom);
        u.busy = 1'($urandom);
        return u;
    endfunction

    function automatic logic will_fire();
        return (inst_0_ops.valid || inst_1_ops.valid) && (free_m >= 2);
    endfunction

    function automatic logic operand_ready(input logic re, input dispatch_pkg::lreg_t laddr,
                                           input dispatch_pkg::prf_num_t pnum, input logic dep);
        if (!re || laddr == '0) begin
            return 1'b1;
        end
        // writeback this cycle hides the busy bit
        if (busy_m[pnum] && !(wb_valid && wb_num == pnum)) begin
            return 1'b0;
        end
        return !dep;
    endfunction

    function automatic logic store_opcode(input dispatch_pkg::uop_e op);
        case (op)
            dispatch_pkg::SB_U, dispatch_pkg::SH_U, dispatch_pkg::SW_U,
            dispatch_pkg::SWL_U, dispatch_pkg::SWR_U: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic mul_opcode(input dispatch_pkg::uop_e op);
        case (op)
            dispatch_pkg::MULTHI_U, dispatch_pkg::MULTLO_U,
            dispatch_pkg::MULTUHI_U, dispatch_pkg::MULTULO_U: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic dispatch_pkg::uop_bundle_t tag_with_id(
        input dispatch_pkg::uop_bundle_t u,
        input logic                      odd
    );
        dispatch_pkg::uop_bundle_t t;
        t = u;
        t.id = {head_m, odd};
        t.busy = u.valid && u.uop != dispatch_pkg::NOP_U && u.uop != dispatch_pkg::MDBUBBLE_U;
        return t;
    endfunction

    // compare all outputs against the model for the current inputs
    task automatic verify_outputs();
        dispatch_pkg::uop_bundle_t       t0;
        dispatch_pkg::uop_bundle_t       t1;
        dispatch_pkg::arbitration_info_t r0;
        dispatch_pkg::arbitration_info_t r1;
        logic fire;
        logic wr0;
        logic a0;
        logic a1;
        logic l0;
        logic l1;
        logic m0;
        fire = will_fire();
        t0 = tag_with_id(inst_0_ops, 1'b0);
        t1 = tag_with_id(inst_1_ops, 1'b1);
        wr0 = inst_0_ops.valid && inst_0_ops.dstwe;
        r0.prs1_rdy = operand_ready(inst_0_ops.op0re, inst_0_ops.op0_laddr,
                                    inst_0_ops.op0_paddr, 1'b0);
        r0.prs2_rdy = operand_ready(inst_0_ops.op1re, inst_0_ops.op1_laddr,
                                    inst_0_ops.op1_paddr, 1'b0);
        r1.prs1_rdy = operand_ready(inst_1_ops.op0re, inst_1_ops.op0_laddr,
                                    inst_1_ops.op0_paddr,
                                    wr0 && inst_0_ops.dst_paddr == inst_1_ops.op0_paddr);
        r1.prs2_rdy = operand_ready(inst_1_ops.op1re, inst_1_ops.op1_laddr,
                                    inst_1_ops.op1_paddr,
                                    wr0 && inst_0_ops.dst_paddr == inst_1_ops.op1_paddr);
        a0 = inst_0_ops.valid && inst_0_ops.rs_type == dispatch_pkg::RS_ALU;
        a1 = inst_1_ops.valid && inst_1_ops.rs_type == dispatch_pkg::RS_ALU;
        l0 = inst_0_ops.valid && inst_0_ops.rs_type == dispatch_pkg::RS_LSU;
        l1 = inst_1_ops.valid && inst_1_ops.rs_type == dispatch_pkg::RS_LSU;
        m0 = inst_0_ops.valid && inst_0_ops.rs_type == dispatch_pkg::RS_MDU;

        check("pause_req", 128'(pause_req), 128'(free_m < 2));
        check("rs_alu_wen_0", 128'(rs_alu_wen_0), 128'(fire && (a0 || a1)));
        check("rs_alu_wen_1", 128'(rs_alu_wen_1), 128'(fire && a0 && a1));
        check("rs_lsu_wen_0", 128'(rs_lsu_wen_0), 128'(fire && (l0 || l1)));
        check("rs_lsu_wen_1", 128'(rs_lsu_wen_1), 128'(fire && l0 && l1));
        check("rs_mdu_wen_0", 128'(rs_mdu_wen_0), 128'(fire && m0));

        // payloads only matter behind an enable
        if (rs_alu_wen_0) begin
            check("rs_alu_dout_0.ops", 128'(rs_alu_dout_0.ops), 128'(a0 ? t0 : t1));
            check("rs_alu_dout_0.rdys", 128'(rs_alu_dout_0.rdys), 128'(a0 ? r0 : r1));
        end
        if (rs_alu_wen_1) begin
            check("rs_alu_dout_1.ops", 128'(rs_alu_dout_1.ops), 128'(t1));
            check("rs_alu_dout_1.rdys", 128'(rs_alu_dout_1.rdys), 128'(r1));
        end
        if (rs_lsu_wen_0) begin
            check("rs_lsu_dout_0.ops", 128'(rs_lsu_dout_0.ops), 128'(l0 ? t0 : t1));
            check("rs_lsu_dout_0.rdys", 128'(rs_lsu_dout_0.rdys), 128'(l0 ? r0 : r1));
            check("rs_lsu_dout_0.is_store", 128'(rs_lsu_dout_0.is_store),
                  128'(store_opcode(l0 ? inst_0_ops.uop : inst_1_ops.uop)));
        end
        if (rs_lsu_wen_1) begin
            check("rs_lsu_dout_1.ops", 128'(rs_lsu_dout_1.ops), 128'(t1));
            check("rs_lsu_dout_1.rdys", 128'(rs_lsu_dout_1.rdys), 128'(r1));
            check("rs_lsu_dout_1.is_store", 128'(rs_lsu_dout_1.is_store),
                  128'(store_opcode(inst_1_ops.uop)));
        end
        if (rs_mdu_wen_0) begin
            check("rs_mdu_dout_0.ops_hi", 128'(rs_mdu_dout_0.ops_hi), 128'(t0));
            check("rs_mdu_dout_0.ops_lo", 128'(rs_mdu_dout_0.ops_lo), 128'(t1));
            check("rs_mdu_dout_0.rdys", 128'(rs_mdu_dout_0.rdys), 128'(r0));
            check("rs_mdu_dout_0.is_mul", 128'(rs_mdu_dout_0.is_mul),
                  128'(mul_opcode(inst_0_ops.uop)));
        end
    endtask

    // model state after the coming edge
    task automatic advance_model();
        logic fire;
        logic commit;
        fire = will_fire();
        commit = commit_pair && free_m != 32;
        if (fire) begin
            head_m = head_m + 5'd1;
            free_m = free_m - 2;
        end
        if (commit) begin
            free_m = free_m + 2;
        end
        // clear first so a set wins
        if (wb_valid) begin
            busy_m[wb_num] = 1'b0;
        end
        if (fire && inst_0_ops.valid && inst_0_ops.dstwe) begin
            busy_m[inst_0_ops.dst_paddr] = 1'b1;
        end
        if (fire && inst_1_ops.valid && inst_1_ops.dstwe) begin
            busy_m[inst_1_ops.dst_paddr] = 1'b1;
        end
    endtask

    initial begin
        dispatch_pkg::uop_bundle_t u0;
        dispatch_pkg::uop_bundle_t u1;
        int   waited;
        logic hold;
        void'($urandom(32'h9873_439c));
        clk = 1'b0;
        arst_n = 1'b0;
        inst_0_ops = '0;
        inst_1_ops = '0;
        wb_valid = 1'b0;
        wb_num = '0;
        commit_pair = 1'b0;
        head_m = '0;
        free_m = 32;
        busy_m = '0;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        // alu pairs with no commits until the rob pushes back
        waited = 0;
        hold = 1'b0;
        do begin
            @(posedge clk);
            u0 = rand_uop();
            u1 = rand_uop();
            u0.valid = 1'b1;
            u0.rs_type = dispatch_pkg::RS_ALU;
            u0.uop = dispatch_pkg::ADD_U;
            u1.valid = 1'b1;
            u1.rs_type = dispatch_pkg::RS_ALU;
            u1.uop = dispatch_pkg::SUB_U;
            if (!hold) begin
                inst_0_ops <= u0;
                inst_1_ops <= u1;
            end
            wb_valid <= 1'b0;
            commit_pair <= 1'b0;
            @(negedge clk);
            if (waited == 0) begin
                // first pair after reset takes slots 0 and 1
                check("pause_req", 128'(pause_req), 128'(0));
                check("rs_alu_dout_0.ops.id", 128'(rs_alu_dout_0.ops.id), 128'(6'h00));
                check("rs_alu_dout_1.ops.id", 128'(rs_alu_dout_1.ops.id), 128'(6'h01));
            end
            verify_outputs();
            hold = pause_req;
            advance_model();
            waited++;
            if (waited > WAIT_LIMIT) begin
                timeout_fail("pause_req to rise");
            end
        end while (!pause_req);
        // 16 pairs go out before the stalled cycle
        check("dispatched cycles", 128'(waited), 128'(17));

        // one commit frees a pair and ids go on with the wrap bit set
        waited = 0;
        do begin
            @(posedge clk);
            commit_pair <= (waited == 0);
            @(negedge clk);
            verify_outputs();
            waited++;
            if (!pause_req) begin
                check("rs_alu_dout_0.ops.id", 128'(rs_alu_dout_0.ops.id), 128'(6'h20));
                check("rs_alu_dout_1.ops.id", 128'(rs_alu_dout_1.ops.id), 128'(6'h21));
            end
            advance_model();
            if (waited > WAIT_LIMIT) begin
                timeout_fail("pause_req to fall");
            end
        end while (pause_req);

        // random traffic with ops held while stalled
        hold = 1'b0;
        for (int i = 0; i < RAND_CYCLES; i++) begin
            @(posedge clk);
            if (!hold) begin
                u0 = rand_uop();
                u1 = rand_uop();
                // intra-pair dependency now and then
                if (($urandom % 4) == 0) begin
                    u1.op0_paddr = u0.dst_paddr;
                end
                if (($urandom % 4) == 0) begin
                    u1.op1_paddr = u0.dst_paddr;
                end
                inst_0_ops <= u0;
                inst_1_ops <= u1;
            end
            wb_valid <= ($urandom % 4) != 0;
            wb_num <= dispatch_pkg::prf_num_t'($urandom % 16);
            commit_pair <= ($urandom % 3) == 0;
            @(negedge clk);
            verify_outputs();
            hold = pause_req;
            advance_model();
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
verilog/dispatch_pkg.sv
verilog/rob_alloc.sv
verilog/busy_table.sv
verilog/dispatch.sv
verilog/dispatch_stage.sv
bench/dispatch_stage_assert.sv
bench/dispatch_stage_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := dispatch_stage_tb
FLIST     := flist.f
PASS_MSG  := All checks passed

OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(wildcard verilog/*.sv bench/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
